//--- src/ntm_logistic_pkg.sv
// Shared definitions for the NTM matrix logistic subsystem
// Widths, PLAN sigmoid constants in signed Q4.12, bus structs and FSM states

package ntm_logistic_pkg;

  ////////////////////
  // Widths

  localparam int DATA_W  = 16;
  // Fractional bits, Q4.12
  localparam int FRAC_W  = 12;
  localparam int INDEX_W = 8;

  ////////////////////
  // Base types

  // One matrix element, input x or result y
  typedef logic [DATA_W-1:0]  data_t;
  // Row or column size and index
  typedef logic [INDEX_W-1:0] index_t;

  ////////////////////
  // PLAN constants

  localparam data_t PLAN_ONE = data_t'(1 << FRAC_W);

  // Segment breakpoints on |x|: 1.0, 2.375, 5.0
  localparam data_t PLAN_B1 = data_t'(1 << FRAC_W);
  localparam data_t PLAN_B2 = data_t'(19 << (FRAC_W - 3));
  localparam data_t PLAN_B3 = data_t'(5 << FRAC_W);

  // Segment offsets: 0.5, 0.625, 0.84375
  localparam data_t PLAN_C1 = data_t'(1 << (FRAC_W - 1));
  localparam data_t PLAN_C2 = data_t'(5 << (FRAC_W - 3));
  localparam data_t PLAN_C3 = data_t'(27 << (FRAC_W - 5));

  ////////////////////
  // Structs

  // Matrix dimensions, sampled with START
  typedef struct packed {
    index_t size_i;
    index_t size_j;
  } ntm_logistic_size_t;

  // One result plus its position flags
  typedef struct packed {
    data_t data;
    logic  row_end;
    logic  matrix_end;
  } ntm_logistic_out_t;

  ////////////////////
  // FSM states

  typedef enum logic [1:0] {STARTER, INPUT, ENDER} matrix_state_t;
  typedef enum logic       {IDLE, BUSY} vector_state_t;

endpackage

//--- src/ntm_scalar_logistic_function.sv
`timescale 1ns/100ps
// Scalar logistic unit
// Two-stage PLAN sigmoid on one signed Q4.12 element, shifts and adds only

module ntm_scalar_logistic_function (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    in_valid,
  input  ntm_logistic_pkg::data_t x,
  output logic                    out_valid,
  output ntm_logistic_pkg::data_t y
);

  ////////////////////
  // Types and signals

  // Segment code 0 below B1, 1 below B2, 2 below B3, 3 saturated
  typedef struct packed {
    logic                    neg;
    logic [1:0]              seg;
    ntm_logistic_pkg::data_t slope;
  } stage_t;

  ntm_logistic_pkg::data_t mag;
  stage_t                  s1_next;
  stage_t                  s1_q;
  logic                    s1_valid;
  ntm_logistic_pkg::data_t offset;
  ntm_logistic_pkg::data_t sum;

  ////////////////////
  // Stage 1

  // Magnitude, -8.0 gives 0x8000 which still reads as 8.0 unsigned
  assign mag = x[ntm_logistic_pkg::DATA_W-1] ? (~x + 1'b1) : x;

  // Segment select and truncating slope shift
  always_comb begin
    s1_next.neg = x[ntm_logistic_pkg::DATA_W-1];
    if (mag >= ntm_logistic_pkg::PLAN_B3) begin
      s1_next.seg   = 2'd3;
      s1_next.slope = '0;
    end else if (mag >= ntm_logistic_pkg::PLAN_B2) begin
      s1_next.seg   = 2'd2;
      s1_next.slope = mag >> 5;
    end else if (mag >= ntm_logistic_pkg::PLAN_B1) begin
      s1_next.seg   = 2'd1;
      s1_next.slope = mag >> 3;
    end else begin
      s1_next.seg   = 2'd0;
      s1_next.slope = mag >> 2;
    end
  end

  always_ff @(posedge CLK) begin
    s1_q <= s1_next;
  end

  ////////////////////
  // Stage 2

  // Offset per segment, saturation adds a full 1.0 to a zero slope
  always_comb begin
    case (s1_q.seg)
      2'd0:    offset = ntm_logistic_pkg::PLAN_C1;
      2'd1:    offset = ntm_logistic_pkg::PLAN_C2;
      2'd2:    offset = ntm_logistic_pkg::PLAN_C3;
      default: offset = ntm_logistic_pkg::PLAN_ONE;
    endcase
  end

  assign sum = s1_q.slope + offset;

  // Symmetry, sigma(-x) = 1 - sigma(x)
  always_ff @(posedge CLK) begin
    y <= s1_q.neg ? (ntm_logistic_pkg::PLAN_ONE - sum) : sum;
  end

  // Valid pipe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  ////////////////////
  // Checks

  // Every segment ends at or below 1.0, so the mirror never wraps
  assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> y <= ntm_logistic_pkg::PLAN_ONE)
    else $error("scalar logistic: result is above 1.0");

endmodule

//--- src/ntm_vector_logistic_function.sv
`timescale 1ns/100ps
// Vector logistic controller
// Walks the columns of one row through the scalar unit
// and flags the result of the last column

module ntm_vector_logistic_function (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  ntm_logistic_pkg::index_t size_j,
  input  logic                     in_valid,
  input  ntm_logistic_pkg::data_t  data_in,
  output logic                     out_valid,
  output ntm_logistic_pkg::data_t  data_out,
  output logic                     row_done
);

  ////////////////////
  // Signals

  ntm_logistic_pkg::vector_state_t state;

  // Latched row length and count of returned results
  ntm_logistic_pkg::index_t size_j_q;
  ntm_logistic_pkg::index_t col;

  logic accept;
  logic last_col;

  // Scalar unit side
  logic                    scalar_valid;
  ntm_logistic_pkg::data_t scalar_x;
  logic                    scalar_out_valid;
  ntm_logistic_pkg::data_t scalar_y;

  ////////////////////
  // Control

  // First element comes together with start, the rest while busy
  assign accept = in_valid && (start || state == ntm_logistic_pkg::BUSY);

  assign last_col = (col == size_j_q - ntm_logistic_pkg::index_t'(1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= ntm_logistic_pkg::IDLE;
      size_j_q     <= '0;
      col          <= '0;
      scalar_valid <= 1'b0;
    end else begin
      scalar_valid <= accept;
      if (start) begin
        // New row
        size_j_q <= size_j;
        col      <= '0;
        state    <= ntm_logistic_pkg::BUSY;
      end else if (state == ntm_logistic_pkg::BUSY && scalar_out_valid) begin
        // Count results, not requests
        if (last_col) begin
          col   <= '0;
          state <= ntm_logistic_pkg::IDLE;
        end else begin
          col <= col + ntm_logistic_pkg::index_t'(1);
        end
      end
    end
  end

  // Element register into the scalar unit
  always_ff @(posedge CLK) begin
    if (accept) begin
      scalar_x <= data_in;
    end
  end

  ////////////////////
  // Scalar unit

  ntm_scalar_logistic_function scalar_logistic (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (scalar_valid),
    .x         (scalar_x),
    .out_valid (scalar_out_valid),
    .y         (scalar_y)
  );

  // Result goes straight back to the matrix controller
  assign out_valid = scalar_out_valid;
  assign data_out  = scalar_y;
  assign row_done  = scalar_out_valid && state == ntm_logistic_pkg::BUSY && last_col;

  ////////////////////
  // Checks

  // Matrix side must wait for row_done before the next row
  assert property (@(posedge CLK) disable iff (RST)
    start |-> state == ntm_logistic_pkg::IDLE)
    else $error("vector logistic: start received while a row is still busy");

endmodule

//--- src/ntm_matrix_logistic_function.sv
`timescale 1ns/100ps
// Matrix logistic controller
// Walks the rows of a matrix, one element in flight at a time,
// and tags each result with row and matrix end flags

module ntm_matrix_logistic_function (
  input  logic                                 CLK,
  input  logic                                 RST,
  input  logic                                 start,
  input  ntm_logistic_pkg::ntm_logistic_size_t size,
  input  logic                                 data_in_enable,
  input  ntm_logistic_pkg::data_t              data_in,
  output logic                                 data_out_enable,
  output ntm_logistic_pkg::ntm_logistic_out_t  data_out,
  output logic                                 ready
);

  ////////////////////
  // Signals

  ntm_logistic_pkg::matrix_state_t state;

  // Latched dimensions and row position
  ntm_logistic_pkg::ntm_logistic_size_t size_q;
  ntm_logistic_pkg::index_t             row;
  logic                                 col_first;
  logic                                 last_row;

  // Vector controller side
  logic                    vec_start;
  logic                    vec_valid;
  ntm_logistic_pkg::data_t vec_data;
  logic                    vec_out_valid;
  ntm_logistic_pkg::data_t vec_data_out;
  logic                    vec_row_done;

  assign last_row = (row == size_q.size_i - ntm_logistic_pkg::index_t'(1));

  ////////////////////
  // Element FSM

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ntm_logistic_pkg::STARTER;
      size_q          <= '0;
      row             <= '0;
      col_first       <= 1'b0;
      vec_start       <= 1'b0;
      vec_valid       <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // Strobes default low
      vec_start       <= 1'b0;
      vec_valid       <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;

      case (state)
        ntm_logistic_pkg::STARTER: begin
          if (start) begin
            size_q    <= size;
            row       <= '0;
            col_first <= 1'b1;
            state     <= ntm_logistic_pkg::INPUT;
          end
        end
        ntm_logistic_pkg::INPUT: begin
          if (data_in_enable) begin
            // Row start rides on the first element
            vec_valid <= 1'b1;
            vec_start <= col_first;
            col_first <= 1'b0;
            state     <= ntm_logistic_pkg::ENDER;
          end
        end
        ntm_logistic_pkg::ENDER: begin
          if (vec_out_valid) begin
            data_out_enable <= 1'b1;
            ready           <= vec_row_done && last_row;
            if (vec_row_done) begin
              col_first <= 1'b1;
              if (last_row) begin
                state <= ntm_logistic_pkg::STARTER;
              end else begin
                row   <= row + ntm_logistic_pkg::index_t'(1);
                state <= ntm_logistic_pkg::INPUT;
              end
            end else begin
              state <= ntm_logistic_pkg::INPUT;
            end
          end
        end
        default: begin
          state <= ntm_logistic_pkg::STARTER;
        end
      endcase
    end
  end

  ////////////////////
  // Payload registers

  always_ff @(posedge CLK) begin
    if (state == ntm_logistic_pkg::INPUT && data_in_enable) begin
      vec_data <= data_in;
    end
    // Flags are only meaningful with data_out_enable
    if (state == ntm_logistic_pkg::ENDER && vec_out_valid) begin
      data_out.data       <= vec_data_out;
      data_out.row_end    <= vec_row_done;
      data_out.matrix_end <= vec_row_done && last_row;
    end
  end

  ////////////////////
  // Vector controller

  ntm_vector_logistic_function vector_logistic (
    .CLK       (CLK),
    .RST       (RST),
    .start     (vec_start),
    .size_j    (size_q.size_j),
    .in_valid  (vec_valid),
    .data_in   (vec_data),
    .out_valid (vec_out_valid),
    .data_out  (vec_data_out),
    .row_done  (vec_row_done)
  );

  ////////////////////
  // Checks

  // No back-pressure, so strobes in the wrong state are lost
  assert property (@(posedge CLK) disable iff (RST)
    data_in_enable |-> state == ntm_logistic_pkg::INPUT)
    else $warning("matrix logistic: element strobe outside INPUT was dropped");

  assert property (@(posedge CLK) disable iff (RST)
    start |-> state == ntm_logistic_pkg::STARTER)
    else $warning("matrix logistic: START outside STARTER was dropped");

  assert property (@(posedge CLK) disable iff (RST)
    start |-> (size.size_i != '0 && size.size_j != '0))
    else $error("matrix logistic: zero matrix size given with START");

endmodule

//--- src/ntm_logistic_top.sv
`timescale 1ns/100ps
// NTM logistic top level
// Element-wise sigmoid over a matrix, external strobe interface

module ntm_logistic_top (
  input  logic                                 CLK,
  input  logic                                 RST,

  // Control
  input  logic                                 START,
  input  ntm_logistic_pkg::ntm_logistic_size_t SIZE,
  output logic                                 READY,

  // Element in
  input  logic                                 DATA_IN_ENABLE,
  input  ntm_logistic_pkg::data_t              DATA_IN,

  // Result out, four cycles after the accepted element
  output logic                                 DATA_OUT_ENABLE,
  output ntm_logistic_pkg::ntm_logistic_out_t  DATA_OUT
);

  ////////////////////
  // Matrix controller

  ntm_matrix_logistic_function matrix_logistic (
    .CLK             (CLK),
    .RST             (RST),
    .start           (START),
    .size            (SIZE),
    .data_in_enable  (DATA_IN_ENABLE),
    .data_in         (DATA_IN),
    .data_out_enable (DATA_OUT_ENABLE),
    .data_out        (DATA_OUT),
    .ready           (READY)
  );

endmodule

//--- bench/ntm_logistic_ref.svh
// Reference model for the NTM logistic testbench
// Piecewise-linear sigmoid on signed Q4.12 and the stimulus random generator

`ifndef NTM_LOGISTIC_REF_SVH
`define NTM_LOGISTIC_REF_SVH

// Piecewise-linear sigmoid, Q4.12 in and out, shifts truncate
function automatic ntm_logistic_pkg::data_t sigmoid_pwl(input ntm_logistic_pkg::data_t x);
  int v;
  int a;
  int r;
  v = int'($signed(x));
  a = (v < 0) ? -v : v;
  // 5.0 = 20480, 2.375 = 9728, 1.0 = 4096
  if (a >= 20480) begin
    r = 4096;
  end else if (a >= 9728) begin
    // 0.84375
    r = (a >> 5) + 3456;
  end else if (a >= 4096) begin
    // 0.625
    r = (a >> 3) + 2560;
  end else begin
    // 0.5
    r = (a >> 2) + 2048;
  end
  // Negative side mirrored around 0.5
  if (v < 0) begin
    r = 4096 - r;
  end
  return ntm_logistic_pkg::data_t'(r);
endfunction

// Linear congruential step, 32-bit state
function automatic logic [31:0] next_random(input logic [31:0] state);
  return state * 32'd1103515245 + 32'd12345;
endfunction

`endif

//--- bench/ntm_logistic_tb.sv
`timescale 1ns/100ps
// Testbench for the NTM logistic top level
// Sends matrices one element at a time, concurrent assertions check every result

module ntm_logistic_tb;

  ////////////////////
  // Run length

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 16;
  // Directed 2x8, then 3x4, 1x5, 4x1 and 6x7
  localparam int TOTAL_ELEMS     = 16 + 12 + 5 + 4 + 42;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_ELEMS * 6 + 200;
  localparam int RESULT_WAIT     = 20;

  logic                                 CLK;
  logic                                 RST;
  logic                                 START;
  ntm_logistic_pkg::ntm_logistic_size_t SIZE;
  logic                                 DATA_IN_ENABLE;
  ntm_logistic_pkg::data_t              DATA_IN;
  logic                                 DATA_OUT_ENABLE;
  ntm_logistic_pkg::ntm_logistic_out_t  DATA_OUT;
  logic                                 READY;

  // Marks strobes that should be accepted, stray strobes leave it low
  logic real_elem;

  // Expected results, head is what the next DATA_OUT must carry
  ntm_logistic_pkg::ntm_logistic_out_t exp_q[$];
  ntm_logistic_pkg::ntm_logistic_out_t exp_head;
  logic                                exp_valid;

  int                      error_count;
  int                      result_count;
  logic [31:0]             rng_state;
  ntm_logistic_pkg::data_t directed [16];

  `include "ntm_logistic_ref.svh"

  ntm_logistic_top UUT (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE            (SIZE),
    .READY           (READY),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  ////////////////////
  // Checks

  // Result registered four edges after the accepting edge, sampled one edge later
  a_latency: assert property (@(posedge CLK) disable iff (RST)
    real_elem |-> ##5 DATA_OUT_ENABLE)
    else begin
      error_count++;
      $display("Result strobe missing four cycles after an accepted element at %0t", $time);
    end

  // No result without an accepted element, covers idle and stray strobes
  a_no_extra: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> $past(real_elem, 5) && exp_valid)
    else begin
      error_count++;
      $display("Unexpected result strobe at %0t", $time);
    end

  a_data: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> DATA_OUT.data == exp_head.data)
    else begin
      error_count++;
      $display("MISMATCH DATA_OUT.data got %h expected %h", DATA_OUT.data, exp_head.data);
    end

  a_row_end: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> DATA_OUT.row_end == exp_head.row_end)
    else begin
      error_count++;
      $display("MISMATCH DATA_OUT.row_end got %h expected %h",
               DATA_OUT.row_end, exp_head.row_end);
    end

  a_matrix_end: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> DATA_OUT.matrix_end == exp_head.matrix_end)
    else begin
      error_count++;
      $display("MISMATCH DATA_OUT.matrix_end got %h expected %h",
               DATA_OUT.matrix_end, exp_head.matrix_end);
    end

  // READY only in the result cycle of the final element
  a_ready: assert property (@(posedge CLK) disable iff (RST)
    READY == ($past(real_elem, 5) && exp_head.matrix_end))
    else begin
      error_count++;
      $display("MISMATCH READY got %h expected %h", READY,
               $past(real_elem, 5) && exp_head.matrix_end);
    end

  // Retire the head on the edge that samples its result
  always @(posedge CLK) begin
    if (DATA_OUT_ENABLE === 1'b1) begin
      result_count++;
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (exp_q.size() > 0) begin
        exp_head = exp_q[0];
      end else begin
        exp_valid = 1'b0;
      end
    end
  end

  ////////////////////
  // Stimulus tasks

  // One element, optional stray strobe in the next cycle, then wait for its result
  task automatic send_element(input ntm_logistic_pkg::data_t value, input logic row_end,
                              input logic matrix_end, input logic stray);
    ntm_logistic_pkg::ntm_logistic_out_t exp;
    int waited;
    exp.data       = sigmoid_pwl(value);
    exp.row_end    = row_end;
    exp.matrix_end = matrix_end;
    exp_q.push_back(exp);
    exp_head  = exp_q[0];
    exp_valid = 1'b1;
    DATA_IN        = value;
    DATA_IN_ENABLE = 1'b1;
    real_elem      = 1'b1;
    @(posedge CLK);
    #2;
    DATA_IN_ENABLE = 1'b0;
    real_elem      = 1'b0;
    if (stray) begin
      // Arrives while the result is pending, must be dropped
      DATA_IN        = ~value;
      DATA_IN_ENABLE = 1'b1;
      @(posedge CLK);
      #2;
      DATA_IN_ENABLE = 1'b0;
    end
    waited = 0;
    while (DATA_OUT_ENABLE !== 1'b1 && waited < RESULT_WAIT) begin
      @(posedge CLK);
      #2;
      waited++;
    end
    if (DATA_OUT_ENABLE !== 1'b1) begin
      error_count++;
      $display("No result within %0d cycles for element %h", RESULT_WAIT, value);
    end
  endtask

  // Whole matrix in row-major order, directed values or random ones
  task automatic run_matrix(input int rows, input int cols, input logic use_directed,
                            input int stray_every);
    ntm_logistic_pkg::data_t value;
    logic                    stray;
    int                      i;
    int                      j;
    int                      n;
    n = 0;
    START       = 1'b1;
    SIZE.size_i = ntm_logistic_pkg::index_t'(rows);
    SIZE.size_j = ntm_logistic_pkg::index_t'(cols);
    @(posedge CLK);
    #2;
    START = 1'b0;
    for (i = 0; i < rows; i++) begin
      for (j = 0; j < cols; j++) begin
        if (use_directed) begin
          value = directed[n % 16];
        end else begin
          rng_state = next_random(rng_state);
          value     = rng_state[31:16];
        end
        stray = (stray_every > 0) && (n % stray_every == stray_every - 1);
        send_element(value, j == cols - 1, (j == cols - 1) && (i == rows - 1), stray);
        n++;
      end
    end
  endtask

  ////////////////////
  // Main sequence

  initial begin
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    SIZE           = '0;
    DATA_IN_ENABLE = 1'b0;
    DATA_IN        = '0;
    real_elem      = 1'b0;
    exp_head       = '0;
    exp_valid      = 1'b0;
    error_count    = 0;
    result_count   = 0;
    rng_state      = 32'he05d;
    // Breakpoints, one LSB either side, negatives and the range limits
    directed = '{16'h0000, 16'h0FFF, 16'h1000, 16'hF000, 16'h25FF, 16'h2600, 16'hDA00,
                 16'hDA01, 16'h4FFF, 16'h5000, 16'hB000, 16'hB001, 16'h7FFF, 16'h8000,
                 16'hFFFF, 16'h0001};
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    RST = 1'b0;
    // Idle, outputs must stay low
    repeat (10) @(posedge CLK);
    #2;
    run_matrix(2, 8, 1'b1, 0);
    run_matrix(3, 4, 1'b0, 0);
    run_matrix(1, 5, 1'b0, 0);
    run_matrix(4, 1, 1'b0, 0);
    // New size after READY, with stray strobes
    run_matrix(6, 7, 1'b0, 3);
    repeat (8) @(posedge CLK);
    if (exp_q.size() != 0) begin
      error_count++;
      $display("%0d expected results never arrived", exp_q.size());
    end
    $display("Results checked: %0d, errors: %0d", result_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- sim.f
+incdir+bench
src/ntm_logistic_pkg.sv
src/ntm_scalar_logistic_function.sv
src/ntm_vector_logistic_function.sv
src/ntm_matrix_logistic_function.sv
src/ntm_logistic_top.sv
bench/ntm_logistic_tb.sv

//--- Bender.yml
package:
  name: ntm_logistic

sources:
  - src/ntm_logistic_pkg.sv
  - src/ntm_scalar_logistic_function.sv
  - src/ntm_vector_logistic_function.sv
  - src/ntm_matrix_logistic_function.sv
  - src/ntm_logistic_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/ntm_logistic_tb.sv
